//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mycpu
FILELIST  = vlog.f
OBJDIR    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^All checks passed$$"

clean:
	rm -rf $(OBJDIR)

//--- design/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   alu_src1,
    input  word_t   alu_src2,
    output word_t   alu_result
);

    word_t      add_result;
    word_t      sub_result;
    word_t      slt_result;
    word_t      sltu_result;
    word_t      and_result;
    word_t      nor_result;
    word_t      or_result;
    word_t      xor_result;
    word_t      sll_result;
    word_t      srl_result;
    word_t      sra_result;
    logic [4:0] shamt;

    assign shamt = alu_src2[4:0];

    assign add_result  = alu_src1 + alu_src2;
    assign sub_result  = alu_src1 - alu_src2;
    assign slt_result  = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
    assign sltu_result = {31'b0, alu_src1 < alu_src2};
    assign and_result  = alu_src1 & alu_src2;
    assign nor_result  = ~(alu_src1 | alu_src2);
    assign or_result   = alu_src1 | alu_src2;
    assign xor_result  = alu_src1 ^ alu_src2;
    assign sll_result  = alu_src1 << shamt;
    assign srl_result  = alu_src1 >> shamt;
    assign sra_result  = word_t'($signed(alu_src1) >>> shamt);

    // and-or select, the code is one-hot or all zero
    assign alu_result = ({32{alu_op[alu_add]}}  & add_result)
                      | ({32{alu_op[alu_sub]}}  & sub_result)
                      | ({32{alu_op[alu_slt]}}  & slt_result)
                      | ({32{alu_op[alu_sltu]}} & sltu_result)
                      | ({32{alu_op[alu_and]}}  & and_result)
                      | ({32{alu_op[alu_nor]}}  & nor_result)
                      | ({32{alu_op[alu_or]}}   & or_result)
                      | ({32{alu_op[alu_xor]}}  & xor_result)
                      | ({32{alu_op[alu_sll]}}  & sll_result)
                      | ({32{alu_op[alu_srl]}}  & srl_result)
                      | ({32{alu_op[alu_sra]}}  & sra_result)
                      | ({32{alu_op[alu_lui]}}  & alu_src2);

endmodule

//--- design/cpu_pkg.sv
package cpu_pkg;

    // datapath widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] alu_op_t;

    typedef enum logic [2:0] {
        st_if,
        st_id,
        st_exe,
        st_mem,
        st_wb
    } cpu_state_t;

    localparam word_t reset_pc = 32'h1c00_0000;

    // 3R and shift-immediate forms, matched on inst[31:15]
    localparam logic [16:0] op17_add_w  = 17'h00020;
    localparam logic [16:0] op17_sub_w  = 17'h00022;
    localparam logic [16:0] op17_slt    = 17'h00024;
    localparam logic [16:0] op17_sltu   = 17'h00025;
    localparam logic [16:0] op17_nor    = 17'h00028;
    localparam logic [16:0] op17_and    = 17'h00029;
    localparam logic [16:0] op17_or     = 17'h0002a;
    localparam logic [16:0] op17_xor    = 17'h0002b;
    localparam logic [16:0] op17_slli_w = 17'h00081;
    localparam logic [16:0] op17_srli_w = 17'h00089;
    localparam logic [16:0] op17_srai_w = 17'h00091;

    // 2RI12 forms, matched on inst[31:22]
    localparam logic [9:0]  op10_addi_w = 10'h00a;
    localparam logic [9:0]  op10_ld_w   = 10'h0a2;
    localparam logic [9:0]  op10_st_w   = 10'h0a6;

    // 1RI20 form, matched on inst[31:25]
    localparam logic [6:0]  op7_lu12i_w = 7'h0a;

    // branch forms, matched on inst[31:26]
    localparam logic [5:0]  op6_jirl    = 6'h13;
    localparam logic [5:0]  op6_b       = 6'h14;
    localparam logic [5:0]  op6_bl      = 6'h15;
    localparam logic [5:0]  op6_beq     = 6'h16;
    localparam logic [5:0]  op6_bne     = 6'h17;

    // one-hot alu select positions
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

endpackage

//--- design/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import cpu_pkg::*; (
    input  word_t    inst,
    output alu_op_t  alu_op,
    output reg_idx_t rf_raddr1,
    output reg_idx_t rf_raddr2,
    output reg_idx_t dest,
    output word_t    imm,
    output word_t    br_offs,
    output logic     src1_is_pc,
    output logic     src2_is_imm,
    output logic     gr_we,
    output logic     mem_we,
    output logic     res_from_mem,
    output logic     is_beq,
    output logic     is_bne,
    output logic     is_jump,
    output logic     is_jirl
);

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;
    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic need_ui5;
    logic need_si20;
    logic need_si26;
    logic src2_is_4;
    logic src_reg_is_rd;

    assign op17 = inst[31:15];
    assign op10 = inst[31:22];
    assign op7  = inst[31:25];
    assign op6  = inst[31:26];
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];
    assign i12  = inst[21:10];
    assign i20  = inst[24:5];
    assign i16  = inst[25:10];
    // offs[25:16] sits in the low bits of the word
    assign i26  = {inst[9:0], inst[25:10]};

    assign inst_add_w   = (op17 == op17_add_w);
    assign inst_sub_w   = (op17 == op17_sub_w);
    assign inst_slt     = (op17 == op17_slt);
    assign inst_sltu    = (op17 == op17_sltu);
    assign inst_nor     = (op17 == op17_nor);
    assign inst_and     = (op17 == op17_and);
    assign inst_or      = (op17 == op17_or);
    assign inst_xor     = (op17 == op17_xor);
    assign inst_slli_w  = (op17 == op17_slli_w);
    assign inst_srli_w  = (op17 == op17_srli_w);
    assign inst_srai_w  = (op17 == op17_srai_w);
    assign inst_addi_w  = (op10 == op10_addi_w);
    assign inst_ld_w    = (op10 == op10_ld_w);
    assign inst_st_w    = (op10 == op10_st_w);
    assign inst_lu12i_w = (op7 == op7_lu12i_w);
    assign inst_jirl    = (op6 == op6_jirl);
    assign inst_b       = (op6 == op6_b);
    assign inst_bl      = (op6 == op6_bl);
    assign inst_beq     = (op6 == op6_beq);
    assign inst_bne     = (op6 == op6_bne);

    always_comb begin
        alu_op = '0;
        // address and link computations reuse the adder
        alu_op[alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                         | inst_jirl | inst_bl;
        alu_op[alu_sub]  = inst_sub_w;
        alu_op[alu_slt]  = inst_slt;
        alu_op[alu_sltu] = inst_sltu;
        alu_op[alu_and]  = inst_and;
        alu_op[alu_nor]  = inst_nor;
        alu_op[alu_or]   = inst_or;
        alu_op[alu_xor]  = inst_xor;
        alu_op[alu_sll]  = inst_slli_w;
        alu_op[alu_srl]  = inst_srli_w;
        alu_op[alu_sra]  = inst_srai_w;
        alu_op[alu_lui]  = inst_lu12i_w;
    end

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si20 = inst_lu12i_w;
    assign need_si26 = inst_b | inst_bl;
    assign src2_is_4 = inst_jirl | inst_bl;

    always_comb begin
        if (src2_is_4) begin
            imm = 32'd4;
        end else if (need_si20) begin
            imm = {i20, 12'b0};
        end else if (need_ui5) begin
            imm = {27'b0, rk};
        end else begin
            imm = {{20{i12[11]}}, i12};
        end
    end

    assign br_offs = need_si26 ? {{4{i26[25]}}, i26, 2'b00}
                               : {{14{i16[15]}}, i16, 2'b00};

    assign src_reg_is_rd = inst_beq | inst_bne | inst_st_w;

    assign rf_raddr1 = rj;
    assign rf_raddr2 = src_reg_is_rd ? rd : rk;
    assign dest      = inst_bl ? 5'd1 : rd;

    assign src1_is_pc   = inst_jirl | inst_bl;
    assign src2_is_imm  = need_ui5 | inst_addi_w | inst_ld_w | inst_st_w
                        | inst_lu12i_w | src2_is_4;
    assign gr_we        = inst_add_w | inst_sub_w | inst_slt | inst_sltu
                        | inst_nor | inst_and | inst_or | inst_xor
                        | need_ui5 | inst_addi_w | inst_lu12i_w | inst_ld_w
                        | inst_jirl | inst_bl;
    assign mem_we       = inst_st_w;
    assign res_from_mem = inst_ld_w;
    assign is_beq       = inst_beq;
    assign is_bne       = inst_bne;
    assign is_jump      = inst_b | inst_bl | inst_jirl;
    assign is_jirl      = inst_jirl;

endmodule

//--- design/mycpu_top.sv
`timescale 1ns/1ps

module mycpu_top import cpu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    output logic        inst_sram_we,
    output word_t       inst_sram_addr,
    output word_t       inst_sram_wdata,
    input  word_t       inst_sram_rdata,
    output logic        data_sram_we,
    output word_t       data_sram_addr,
    output word_t       data_sram_wdata,
    input  word_t       data_sram_rdata,
    output word_t       debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output reg_idx_t    debug_wb_rf_wnum,
    output word_t       debug_wb_rf_wdata
);

    logic       reset;
    cpu_state_t state;
    cpu_state_t state_next;

    word_t pc;
    word_t npc;
    word_t npc_d;
    word_t ir;
    word_t inst;
    word_t src1_q;
    word_t src2_q;
    word_t result_q;
    word_t mem_addr_q;
    word_t mem_wdata_q;

    alu_op_t  alu_op;
    reg_idx_t rf_raddr1;
    reg_idx_t rf_raddr2;
    reg_idx_t dest;
    word_t    imm;
    word_t    br_offs;
    logic     src1_is_pc;
    logic     src2_is_imm;
    logic     gr_we;
    logic     mem_we;
    logic     res_from_mem;
    logic     is_beq;
    logic     is_bne;
    logic     is_jump;
    logic     is_jirl;

    word_t rf_rdata1;
    word_t rf_rdata2;
    logic  rf_we;
    word_t alu_result;
    logic  br_taken;
    word_t br_target;

    always_ff @(posedge clk) begin
        reset <= ~resetn;
    end

    // the fetched word is only on rdata during st_id
    assign inst = (state == st_id) ? inst_sram_rdata : ir;

    inst_decoder u_decoder (
        .inst         (inst),
        .alu_op       (alu_op),
        .rf_raddr1    (rf_raddr1),
        .rf_raddr2    (rf_raddr2),
        .dest         (dest),
        .imm          (imm),
        .br_offs      (br_offs),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .gr_we        (gr_we),
        .mem_we       (mem_we),
        .res_from_mem (res_from_mem),
        .is_beq       (is_beq),
        .is_bne       (is_bne),
        .is_jump      (is_jump),
        .is_jirl      (is_jirl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (dest),
        .wdata  (result_q)
    );

    alu u_alu (
        .alu_op     (alu_op),
        .alu_src1   (src1_q),
        .alu_src2   (src2_q),
        .alu_result (alu_result)
    );

    // branch resolution, meaningful in st_id only
    assign br_taken  = is_jump
                     | (is_beq & (rf_rdata1 == rf_rdata2))
                     | (is_bne & (rf_rdata1 != rf_rdata2));
    assign br_target = (is_jirl ? rf_rdata1 : pc) + br_offs;
    assign npc_d     = br_taken ? br_target : pc + 32'd4;

    always_comb begin
        case (state)
            st_if:   state_next = st_id;
            // b, beq, bne and undefined words end here
            st_id:   state_next = (gr_we | mem_we) ? st_exe : st_if;
            st_exe:  state_next = (mem_we | res_from_mem) ? st_mem : st_wb;
            st_mem:  state_next = res_from_mem ? st_wb : st_if;
            st_wb:   state_next = st_if;
            default: state_next = st_if;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_if;
            pc    <= reset_pc;
        end else begin
            state <= state_next;
            if (state_next == st_if) begin
                pc <= (state == st_id) ? npc_d : npc;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_id: begin
                ir     <= inst_sram_rdata;
                npc    <= npc_d;
                src1_q <= src1_is_pc ? pc : rf_rdata1;
                src2_q <= src2_is_imm ? imm : rf_rdata2;
            end
            st_exe: begin
                result_q    <= alu_result;
                mem_addr_q  <= alu_result;
                mem_wdata_q <= rf_rdata2;
            end
            st_mem: begin
                if (res_from_mem) begin
                    result_q <= data_sram_rdata;
                end
            end
            default: begin
            end
        endcase
    end

    assign inst_sram_we    = 1'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = 32'd0;

    // address goes out in st_exe already so load data is back in st_mem
    assign data_sram_addr  = (state == st_exe) ? alu_result : mem_addr_q;
    assign data_sram_wdata = mem_wdata_q;
    assign data_sram_we    = (state == st_mem) & mem_we;

    assign rf_we = (state == st_wb) & gr_we;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = result_q;

endmodule

//--- design/regfile.sv
`timescale 1ns/1ps

module regfile import cpu_pkg::*; (
    input  logic     clk,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t rf [32];

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 is never written, so it is forced on the read side
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

//--- testbench/mycpu_chk.sv
`timescale 1ns/1ps

module mycpu_chk import cpu_pkg::*; (
    input logic       clk,
    input logic       reset,
    input cpu_state_t state,
    input word_t      pc,
    input logic       data_sram_we,
    input logic [3:0] debug_wb_rf_we
);

    // legal state paths
    assert property (@(posedge clk) disable iff (reset !== 1'b0)
        state == st_if |=> state == st_id)
        else $error("st_if not followed by st_id");
    assert property (@(posedge clk) disable iff (reset !== 1'b0)
        state == st_id |=> (state == st_exe || state == st_if))
        else $error("illegal state after st_id");
    assert property (@(posedge clk) disable iff (reset !== 1'b0)
        state == st_exe |=> (state == st_mem || state == st_wb))
        else $error("illegal state after st_exe");
    assert property (@(posedge clk) disable iff (reset !== 1'b0)
        state == st_mem |=> (state == st_wb || state == st_if))
        else $error("illegal state after st_mem");
    assert property (@(posedge clk) disable iff (reset !== 1'b0)
        state == st_wb |=> state == st_if)
        else $error("st_wb not followed by st_if");

    // one trace record per retired instruction
    assert property (@(posedge clk) disable iff (reset !== 1'b0)
        debug_wb_rf_we != 4'h0 |=> debug_wb_rf_we == 4'h0)
        else $error("debug_wb_rf_we held for more than one cycle");
    assert property (@(posedge clk) disable iff (reset !== 1'b0)
        data_sram_we |-> state == st_mem)
        else $error("data_sram_we high outside st_mem");
    assert property (@(posedge clk) disable iff (reset !== 1'b0)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

//--- testbench/tb_mycpu.sv
`timescale 1ns/1ps

module tb_mycpu import cpu_pkg::*; ();

    localparam int    prog_len = 200;
    localparam int    cycle_ns = 4;
    localparam word_t loop_pc  = reset_pc + 32'(4 * (prog_len - 1));

    logic       clk;
    logic       resetn = 1'b0;
    logic       inst_sram_we;
    word_t      inst_sram_addr;
    word_t      inst_sram_wdata;
    word_t      inst_sram_rdata = '0;
    logic       data_sram_we;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata = '0;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t    imem [256];
    word_t    dmem [512];
    word_t    exp_pc [$];
    reg_idx_t exp_num [$];
    word_t    exp_data [$];
    word_t    exp_st_addr [$];
    word_t    exp_st_data [$];
    int       model_writes;
    int       model_stores;
    int       writes_seen = 0;
    int       stores_seen = 0;
    logic     started = 1'b0;

    mycpu_top i_dut (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    bind mycpu_top mycpu_chk u_chk (
        .clk            (clk),
        .reset          (reset),
        .state          (state),
        .pc             (pc),
        .data_sram_we   (data_sram_we),
        .debug_wb_rf_we (debug_wb_rf_we)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check(string name, word_t exp, word_t act);
        if (exp !== act) begin
            fail_run($sformatf("FAIL %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    // both memories read synchronously, writes land on the same edge
    always @(posedge clk) begin : sram_models
        word_t ia;
        word_t da;
        word_t dw;
        logic  dwe;
        ia = inst_sram_addr;
        da = data_sram_addr;
        dw = data_sram_wdata;
        dwe = data_sram_we;
        #1;
        inst_sram_rdata = imem[ia[9:2]];
        data_sram_rdata = dmem[da[10:2]];
        if (dwe === 1'b1) begin
            dmem[da[10:2]] = dw;
        end
    end

    function automatic reg_idx_t rand_reg();
        return reg_idx_t'($urandom % 8);
    endfunction

    function automatic logic known_op(word_t w);
        return (w[31:15] inside {op17_add_w, op17_sub_w, op17_slt, op17_sltu, op17_nor,
                                 op17_and, op17_or, op17_xor, op17_slli_w, op17_srli_w,
                                 op17_srai_w})
            || (w[31:22] inside {op10_addi_w, op10_ld_w, op10_st_w})
            || (w[31:25] == op7_lu12i_w)
            || (w[31:26] inside {op6_jirl, op6_b, op6_bl, op6_beq, op6_bne});
    endfunction

    task automatic put(int idx, word_t w);
        imem[8'(idx)] = w;
    endtask

    task automatic gen_program();
        logic [16:0] ops3r [8];
        logic [16:0] opsh [3];
        int          i;
        int          t;
        int          kind;
        word_t       w;
        logic [25:0] off;
        ops3r = '{op17_add_w, op17_sub_w, op17_slt, op17_sltu,
                  op17_nor, op17_and, op17_or, op17_xor};
        opsh = '{op17_slli_w, op17_srli_w, op17_srai_w};
        for (int n = 0; n < 256; n++) imem[n] = '0;
        for (int n = 0; n < 512; n++) dmem[n] = '0;
        // r31 holds the program base for jirl, r1..r7 get random values
        put(0, {op7_lu12i_w, 20'h1c000, 5'd31});
        for (i = 1; i < 8; i++) put(i, {op10_addi_w, 12'($urandom), 5'd0, 5'(i)});
        i = 8;
        while (i < prog_len - 1) begin
            kind = int'($urandom % 18);
            t = i + 1 + int'($urandom % 4);
            if (t > prog_len - 1) t = prog_len - 1;
            off = 26'(t - i);
            if (kind < 7) begin
                w = {ops3r[3'($urandom % 8)], rand_reg(), rand_reg(), rand_reg()};
            end else if (kind == 7) begin
                w = {opsh[2'($urandom % 3)], 5'($urandom), rand_reg(), rand_reg()};
            end else if (kind == 8) begin
                w = {op10_addi_w, 12'($urandom), rand_reg(), rand_reg()};
            end else if (kind == 9) begin
                w = {op7_lu12i_w, 20'($urandom), rand_reg()};
            end else if (kind == 10 || kind == 11) begin
                // a small window so loads often hit earlier stores
                w = {(kind == 10) ? op10_ld_w : op10_st_w, 12'(($urandom % 16) * 4),
                     5'd0, rand_reg()};
            end else if (kind == 12 || kind == 13) begin
                w = {($urandom % 2 == 0) ? op6_beq : op6_bne, off[15:0], rand_reg(), rand_reg()};
            end else if (kind == 14) begin
                w = {($urandom % 2 == 0) ? op6_b : op6_bl, off[15:0], off[25:16]};
            end else if (kind == 15 && i < prog_len - 3) begin
                put(i, {op7_lu12i_w, 20'h1c000, 5'd31});
                i++;
                t = i + 1 + int'($urandom % 4);
                if (t > prog_len - 1) t = prog_len - 1;
                // offset is relative to r31, i.e. the word index of the target
                w = {op6_jirl, 16'(t), 5'd31, rand_reg()};
            end else begin
                do w = $urandom; while (known_op(w));
            end
            put(i, w);
            i++;
        end
        put(prog_len - 1, {op6_b, 26'd0});
    endtask

    // reference ISA model, runs until the self loop
    task automatic run_model();
        word_t    r [32];
        word_t    dm [512];
        word_t    pc;
        word_t    npc;
        word_t    w;
        word_t    res;
        word_t    a;
        word_t    o16;
        word_t    o26;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        logic     wr;
        for (int n = 0; n < 32; n++) r[n] = '0;
        for (int n = 0; n < 512; n++) dm[n] = '0;
        pc = reset_pc;
        model_writes = 0;
        model_stores = 0;
        for (int steps = 0; steps < 4 * prog_len; steps++) begin
            w = imem[pc[9:2]];
            if (pc == loop_pc) break;
            rd = w[4:0];
            rj = w[9:5];
            rk = w[14:10];
            a = r[rj] + {{20{w[21]}}, w[21:10]};
            o16 = {{14{w[25]}}, w[25:10], 2'b00};
            o26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            wr = 1'b1;
            res = '0;
            npc = pc + 32'd4;
            if (w[31:15] == op17_add_w) res = r[rj] + r[rk];
            else if (w[31:15] == op17_sub_w) res = r[rj] - r[rk];
            else if (w[31:15] == op17_slt) res = {31'b0, $signed(r[rj]) < $signed(r[rk])};
            else if (w[31:15] == op17_sltu) res = {31'b0, r[rj] < r[rk]};
            else if (w[31:15] == op17_nor) res = ~(r[rj] | r[rk]);
            else if (w[31:15] == op17_and) res = r[rj] & r[rk];
            else if (w[31:15] == op17_or) res = r[rj] | r[rk];
            else if (w[31:15] == op17_xor) res = r[rj] ^ r[rk];
            else if (w[31:15] == op17_slli_w) res = r[rj] << rk;
            else if (w[31:15] == op17_srli_w) res = r[rj] >> rk;
            else if (w[31:15] == op17_srai_w) res = word_t'($signed(r[rj]) >>> rk);
            else if (w[31:22] == op10_addi_w) res = a;
            else if (w[31:22] == op10_ld_w) res = dm[a[10:2]];
            else if (w[31:22] == op10_st_w) begin
                wr = 1'b0;
                dm[a[10:2]] = r[rd];
                exp_st_addr.push_back(a);
                exp_st_data.push_back(r[rd]);
                model_stores++;
            end else if (w[31:25] == op7_lu12i_w) res = {w[24:5], 12'b0};
            else if (w[31:26] == op6_jirl) begin
                res = pc + 32'd4;
                npc = r[rj] + o16;
            end else if (w[31:26] == op6_bl) begin
                res = pc + 32'd4;
                rd = 5'd1;
                npc = pc + o26;
            end else begin
                wr = 1'b0;
                if (w[31:26] == op6_b) npc = pc + o26;
                if (w[31:26] == op6_beq && r[rj] == r[rd]) npc = pc + o16;
                if (w[31:26] == op6_bne && r[rj] != r[rd]) npc = pc + o16;
            end
            if (wr) begin
                exp_pc.push_back(pc);
                exp_num.push_back(rd);
                exp_data.push_back(res);
                model_writes++;
                if (rd != 5'd0) r[rd] = res;
            end
            pc = npc;
        end
    endtask

    always @(negedge clk) begin
        if (started) begin
            // the instruction port never writes
            check("inst_sram_we", 32'd0, word_t'(inst_sram_we));
            check("inst_sram_wdata", 32'd0, inst_sram_wdata);
        end
        if (started && debug_wb_rf_we != 4'h0) begin
            if (exp_pc.size() == 0) fail_run("register write seen with no write left in the model");
            check("debug_wb_pc", exp_pc.pop_front(), debug_wb_pc);
            check("debug_wb_rf_wnum", word_t'(exp_num.pop_front()), word_t'(debug_wb_rf_wnum));
            check("debug_wb_rf_wdata", exp_data.pop_front(), debug_wb_rf_wdata);
            writes_seen++;
        end
        if (started && data_sram_we) begin
            if (exp_st_addr.size() == 0) fail_run("store seen with no store left in the model");
            check("data_sram_addr", exp_st_addr.pop_front(), data_sram_addr);
            check("data_sram_wdata", exp_st_data.pop_front(), data_sram_wdata);
            stores_seen++;
        end
    end

    initial begin
        #(cycle_ns * (5 * prog_len + 200));
        fail_run("timeout, the program never reached its final loop");
    end

    initial begin
        void'($urandom(32'he9d5));
        gen_program();
        run_model();
        repeat (4) @(posedge clk);
        #1 resetn = 1'b1;
        // internal reset still holds for one more cycle
        @(posedge clk);
        @(negedge clk);
        check("debug_wb_rf_we", 32'd0, word_t'(debug_wb_rf_we));
        check("data_sram_we", 32'd0, word_t'(data_sram_we));
        check("inst_sram_addr", reset_pc, inst_sram_addr);
        started = 1'b1;
        while (inst_sram_addr != loop_pc) @(negedge clk);
        repeat (20) @(negedge clk);
        check("register write count", word_t'(model_writes), word_t'(writes_seen));
        check("store count", word_t'(model_stores), word_t'(stores_seen));
        check("writes left in model", 32'd0, word_t'(exp_pc.size()));
        check("stores left in model", 32'd0, word_t'(exp_st_addr.size()));
        $display("All checks passed");
        $finish;
    end

endmodule

//--- vlog.f
design/cpu_pkg.sv
design/inst_decoder.sv
design/alu.sv
design/regfile.sv
design/mycpu_top.sv
testbench/mycpu_chk.sv
testbench/tb_mycpu.sv
